/* rtl/sram_pkg.sv */
package sram_pkg;

    // Bank geometry
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;
    localparam int MASK_W = 4;
    localparam int BYTE_W = DATA_W / MASK_W;
    localparam int DEPTH  = 256;

    // Command packet width, bank select plus port fields
    localparam int PKT_W  = 56;

    typedef enum logic [0:0] {
        BANK0 = 1'b0,
        BANK1 = 1'b1
    } bank_sel_e;

    // Decoded operation on the read/write port
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_op_e;

    // Same bit layout as the legacy 56-bit packet
    // Bit 55 is the bank, bits 54..0 the port fields
    typedef struct packed {
        bank_sel_e         bank;
        logic              rw_csb;
        logic              rw_web;
        logic [MASK_W-1:0] wmask;
        logic [ADDR_W-1:0] rw_addr;
        logic [DATA_W-1:0] wdata;
        logic              ro_csb;
        logic [ADDR_W-1:0] ro_addr;
    } sram_packet_t;

    // Read/write port request to one bank
    typedef struct packed {
        rw_op_e            op;
        logic [MASK_W-1:0] wmask;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } rw_req_t;

    // Read-only port request, enable is active high
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } ro_req_t;

    // One port's read response
    typedef struct packed {
        logic              valid;
        bank_sel_e         bank;
        logic [DATA_W-1:0] data;
    } read_rsp_t;

endpackage

/* rtl/sram_packet_router.sv */
module sram_packet_router (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   pkt_valid,
    input  sram_pkg::sram_packet_t pkt,
    output sram_pkg::rw_req_t      rw_req0,
    output sram_pkg::rw_req_t      rw_req1,
    output sram_pkg::ro_req_t      ro_req0,
    output sram_pkg::ro_req_t      ro_req1,
    output sram_pkg::bank_sel_e    rd_bank,
    output logic                   rw_rd,
    output logic                   ro_rd
);
    import sram_pkg::*;

    // Decoded packet controls
    rw_op_e            dec_op;
    logic              dec_ro_en;

    // Next per-bank controls
    rw_op_e            op0_d;
    rw_op_e            op1_d;
    logic              ro_en0_d;
    logic              ro_en1_d;

    // Registered controls
    rw_op_e            op0_q;
    rw_op_e            op1_q;
    logic              ro_en0_q;
    logic              ro_en1_q;
    bank_sel_e         bank_q;
    logic              rw_rd_q;
    logic              ro_rd_q;

    // Registered payload, shared by both banks
    logic [MASK_W-1:0] wmask_q;
    logic [ADDR_W-1:0] rw_addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [ADDR_W-1:0] ro_addr_q;

    // Active-low selects to operations
    always_comb begin
        if (pkt.rw_csb) begin
            dec_op = RW_IDLE;
        end else if (pkt.rw_web) begin
            dec_op = RW_READ;
        end else begin
            dec_op = RW_WRITE;
        end
    end

    assign dec_ro_en = ~pkt.ro_csb;

    // Steer to the selected bank, other bank stays idle
    always_comb begin
        op0_d    = RW_IDLE;
        op1_d    = RW_IDLE;
        ro_en0_d = 1'b0;
        ro_en1_d = 1'b0;
        if (pkt_valid) begin
            case (pkt.bank)
                BANK0: begin
                    op0_d    = dec_op;
                    ro_en0_d = dec_ro_en;
                end
                BANK1: begin
                    op1_d    = dec_op;
                    ro_en1_d = dec_ro_en;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            op0_q    <= RW_IDLE;
            op1_q    <= RW_IDLE;
            ro_en0_q <= 1'b0;
            ro_en1_q <= 1'b0;
            bank_q   <= BANK0;
            rw_rd_q  <= 1'b0;
            ro_rd_q  <= 1'b0;
        end else begin
            op0_q    <= op0_d;
            op1_q    <= op1_d;
            ro_en0_q <= ro_en0_d;
            ro_en1_q <= ro_en1_d;
            rw_rd_q  <= pkt_valid && (dec_op == RW_READ);
            ro_rd_q  <= pkt_valid && dec_ro_en;
            if (pkt_valid) begin
                bank_q <= pkt.bank;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pkt_valid) begin
            wmask_q   <= pkt.wmask;
            rw_addr_q <= pkt.rw_addr;
            wdata_q   <= pkt.wdata;
            ro_addr_q <= pkt.ro_addr;
        end
    end

    assign rw_req0 = '{op: op0_q, wmask: wmask_q, addr: rw_addr_q, wdata: wdata_q};
    assign rw_req1 = '{op: op1_q, wmask: wmask_q, addr: rw_addr_q, wdata: wdata_q};
    assign ro_req0 = '{en: ro_en0_q, addr: ro_addr_q};
    assign ro_req1 = '{en: ro_en1_q, addr: ro_addr_q};

    // Read-issue flags for the read return
    assign rd_bank = bank_q;
    assign rw_rd   = rw_rd_q;
    assign ro_rd   = ro_rd_q;

endmodule

/* rtl/sram_bank_model.sv */
module sram_bank_model (
    input  logic                          clk_in,
    input  logic                          rst_n,
    input  sram_pkg::rw_req_t             rw_req,
    input  sram_pkg::ro_req_t             ro_req,
    output logic [sram_pkg::DATA_W-1:0]   rw_dout,
    output logic [sram_pkg::DATA_W-1:0]   ro_dout
);
    import sram_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];

    logic [DATA_W-1:0] rw_dout_q;
    logic [DATA_W-1:0] ro_dout_q;

    logic              rw_is_write;
    logic              rw_is_read;

    assign rw_is_write = (rw_req.op == RW_WRITE);
    assign rw_is_read  = (rw_req.op == RW_READ);

    // Byte-masked write
    always_ff @(posedge clk_in) begin
        if (rw_is_write) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (rw_req.wmask[b]) begin
                    mem[rw_req.addr][b*BYTE_W +: BYTE_W] <= rw_req.wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // Registered reads
    // Nonblocking update gives read before write on a same-address collision
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rw_dout_q <= '0;
            ro_dout_q <= '0;
        end else begin
            if (rw_is_read) begin
                rw_dout_q <= mem[rw_req.addr];
            end
            if (ro_req.en) begin
                ro_dout_q <= mem[ro_req.addr];
            end
        end
    end

    // Outputs hold while the port is idle
    assign rw_dout = rw_dout_q;
    assign ro_dout = ro_dout_q;

endmodule

/* rtl/sram_read_return.sv */
module sram_read_return (
    input  logic                        clk_in,
    input  logic                        rst_n,
    input  sram_pkg::bank_sel_e         rd_bank,
    input  logic                        rw_rd,
    input  logic                        ro_rd,
    input  logic [sram_pkg::DATA_W-1:0] rw_dout0,
    input  logic [sram_pkg::DATA_W-1:0] ro_dout0,
    input  logic [sram_pkg::DATA_W-1:0] rw_dout1,
    input  logic [sram_pkg::DATA_W-1:0] ro_dout1,
    output sram_pkg::read_rsp_t         rw_rsp,
    output sram_pkg::read_rsp_t         ro_rsp
);
    import sram_pkg::*;

    // Read-issue tag, one cycle behind the router
    bank_sel_e         bank_q;
    logic              rw_rd_q;
    logic              ro_rd_q;

    // Data from the addressed bank
    logic [DATA_W-1:0] rw_sel;
    logic [DATA_W-1:0] ro_sel;

    read_rsp_t         rw_rsp_q;
    read_rsp_t         ro_rsp_q;

    // Lines up with the bank output registers
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            bank_q  <= BANK0;
            rw_rd_q <= 1'b0;
            ro_rd_q <= 1'b0;
        end else begin
            bank_q  <= rd_bank;
            rw_rd_q <= rw_rd;
            ro_rd_q <= ro_rd;
        end
    end

    assign rw_sel = (bank_q == BANK1) ? rw_dout1 : rw_dout0;
    assign ro_sel = (bank_q == BANK1) ? ro_dout1 : ro_dout0;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rw_rsp_q <= '{valid: 1'b0, bank: BANK0, data: '0};
            ro_rsp_q <= '{valid: 1'b0, bank: BANK0, data: '0};
        end else begin
            // Valid pulses for one cycle, data hold otherwise
            rw_rsp_q.valid <= rw_rd_q;
            ro_rsp_q.valid <= ro_rd_q;
            if (rw_rd_q) begin
                rw_rsp_q.bank <= bank_q;
                rw_rsp_q.data <= rw_sel;
            end
            if (ro_rd_q) begin
                ro_rsp_q.bank <= bank_q;
                ro_rsp_q.data <= ro_sel;
            end
        end
    end

    assign rw_rsp = rw_rsp_q;
    assign ro_rsp = ro_rsp_q;

endmodule

/* rtl/sram_subsystem.sv */
module sram_subsystem (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   pkt_valid,
    input  sram_pkg::sram_packet_t pkt,
    output sram_pkg::read_rsp_t    rw_rsp,
    output sram_pkg::read_rsp_t    ro_rsp
);
    import sram_pkg::*;

    // Router to banks
    rw_req_t           rw_req0;
    rw_req_t           rw_req1;
    ro_req_t           ro_req0;
    ro_req_t           ro_req1;

    // Router to read return
    bank_sel_e         rd_bank;
    logic              rw_rd;
    logic              ro_rd;

    // Bank read data
    logic [DATA_W-1:0] rw_dout0;
    logic [DATA_W-1:0] ro_dout0;
    logic [DATA_W-1:0] rw_dout1;
    logic [DATA_W-1:0] ro_dout1;

    sram_packet_router u_router (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .rw_req0   (rw_req0),
        .rw_req1   (rw_req1),
        .ro_req0   (ro_req0),
        .ro_req1   (ro_req1),
        .rd_bank   (rd_bank),
        .rw_rd     (rw_rd),
        .ro_rd     (ro_rd)
    );

    sram_bank_model u_bank0 (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rw_req  (rw_req0),
        .ro_req  (ro_req0),
        .rw_dout (rw_dout0),
        .ro_dout (ro_dout0)
    );

    sram_bank_model u_bank1 (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rw_req  (rw_req1),
        .ro_req  (ro_req1),
        .rw_dout (rw_dout1),
        .ro_dout (ro_dout1)
    );

    sram_read_return u_read_return (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rd_bank  (rd_bank),
        .rw_rd    (rw_rd),
        .ro_rd    (ro_rd),
        .rw_dout0 (rw_dout0),
        .ro_dout0 (ro_dout0),
        .rw_dout1 (rw_dout1),
        .ro_dout1 (ro_dout1),
        .rw_rsp   (rw_rsp),
        .ro_rsp   (ro_rsp)
    );

endmodule

/* verif/tb_sram_subsystem.sv */
module tb_sram_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import sram_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int N_RANDOM     = 40;
    localparam int PIPE_DEPTH   = 3;
    localparam int DRAIN_CYCLES = 4;
    localparam int N_PRELOAD    = 8;

    typedef struct packed {
        logic         valid;
        sram_packet_t pkt;
    } stim_t;

    logic         clk_in = 1'b0;
    logic         rst_n;
    logic         pkt_valid;
    sram_packet_t pkt;
    read_rsp_t    rw_rsp;
    read_rsp_t    ro_rsp;

    stim_t             stim_q[$];
    read_rsp_t         exp_rw_q[$];
    read_rsp_t         exp_ro_q[$];
    logic [DATA_W-1:0] ref_mem [2][DEPTH];
    logic [31:0]       rng_state;
    logic              table_built = 1'b0;

    sram_subsystem UUT (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .rw_rsp    (rw_rsp),
        .ro_rsp    (ro_rsp)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic sram_packet_t make_pkt(bank_sel_e bank, logic rw_csb, logic rw_web,
                                              logic [MASK_W-1:0] wmask,
                                              logic [ADDR_W-1:0] rw_addr,
                                              logic [DATA_W-1:0] wdata, logic ro_csb,
                                              logic [ADDR_W-1:0] ro_addr);
        sram_packet_t p;
        p.bank    = bank;
        p.rw_csb  = rw_csb;
        p.rw_web  = rw_web;
        p.wmask   = wmask;
        p.rw_addr = rw_addr;
        p.wdata   = wdata;
        p.ro_csb  = ro_csb;
        p.ro_addr = ro_addr;
        return p;
    endfunction

    // Preload word that depends on every address bit
    function automatic logic [DATA_W-1:0] fill_word(bank_sel_e bank, logic [ADDR_W-1:0] addr);
        return {addr ^ 8'hc3, ~addr, 7'd0, bank, addr};
    endfunction

    task automatic add_row(logic valid, sram_packet_t p);
        stim_q.push_back('{valid: valid, pkt: p});
    endtask

    task automatic add_write(bank_sel_e bank, logic [MASK_W-1:0] mask,
                             logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
        add_row(1'b1, make_pkt(bank, 1'b0, 1'b0, mask, addr, data, 1'b1, '0));
    endtask

    task automatic add_rw_read(bank_sel_e bank, logic [ADDR_W-1:0] addr);
        add_row(1'b1, make_pkt(bank, 1'b0, 1'b1, '0, addr, '0, 1'b1, '0));
    endtask

    task automatic add_ro_read(bank_sel_e bank, logic [ADDR_W-1:0] addr);
        add_row(1'b1, make_pkt(bank, 1'b1, 1'b1, '0, '0, '0, 1'b0, addr));
    endtask

    task automatic build_table();
        logic [31:0]  r;
        sram_packet_t p;
        // Random rows only touch addresses written here
        for (int a = 0; a < N_PRELOAD; a++) begin
            add_write(BANK0, 4'hf, ADDR_W'(a), fill_word(BANK0, ADDR_W'(a)));
            add_write(BANK1, 4'hf, ADDR_W'(a), fill_word(BANK1, ADDR_W'(a)));
        end
        // No response for both selects high or for the strobe low
        add_row(1'b1, make_pkt(BANK0, 1'b1, 1'b1, 4'hf, 8'd1, 32'h0, 1'b1, 8'd1));
        add_row(1'b1, make_pkt(BANK1, 1'b1, 1'b0, 4'hf, 8'd1, 32'hffff_ffff, 1'b1, 8'd1));
        add_row(1'b0, make_pkt(BANK0, 1'b0, 1'b0, 4'hf, 8'd1, 32'h5555_aaaa, 1'b1, 8'd0));
        add_rw_read(BANK0, 8'd1);
        add_rw_read(BANK1, 8'd1);
        add_write(BANK1, 4'hf, 8'd3, 32'hdead_beef);
        add_rw_read(BANK1, 8'd3);
        add_write(BANK0, 4'b0101, 8'd5, 32'h1122_3344);
        add_ro_read(BANK0, 8'd5);
        add_write(BANK0, 4'hf, 8'd6, 32'h0bad_cafe);
        add_rw_read(BANK1, 8'd6);
        add_ro_read(BANK1, 8'd6);
        add_rw_read(BANK0, 8'd6);
        // Write and read-only read of one address in a single packet
        add_row(1'b1, make_pkt(BANK1, 1'b0, 1'b0, 4'hf, 8'd2, 32'hcafe_f00d, 1'b0, 8'd2));
        add_rw_read(BANK1, 8'd2);
        add_row(1'b1, make_pkt(BANK0, 1'b0, 1'b1, '0, 8'd4, '0, 1'b0, 8'd7));
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            rng_state = xorshift32(rng_state);
            p = make_pkt(bank_sel_e'(r[0]), r[2:1] == 2'b00, r[3], r[7:4], {5'd0, r[10:8]},
                         rng_state, r[11] & r[12], {5'd0, r[15:13]});
            add_row(r[19:16] != 4'd0, p);
        end
    endtask

    task automatic check_rsp(string name, read_rsp_t act, read_rsp_t exp);
        if (act !== exp) begin
            $display("FAILED %s: valid %h bank %h data %h, expected valid %h bank %h data %h",
                     name, act.valid, act.bank, act.data, exp.valid, exp.bank, exp.data);
            $display("Simulation failed");
            $fatal(1, "Read response mismatch on %s", name);
        end
    endtask

    task automatic check_idle(string name, read_rsp_t act);
        if (act.valid !== 1'b0) begin
            $display("FAILED %s.valid: got %h, expected 0", name, act.valid);
            $display("Simulation failed");
            $fatal(1, "Unexpected response on %s", name);
        end
    endtask

    // Response for a row is due three falling edges after it is driven
    task automatic check_outputs();
        read_rsp_t e_rw;
        read_rsp_t e_ro;
        e_rw = exp_rw_q.pop_front();
        e_ro = exp_ro_q.pop_front();
        if (e_rw.valid) begin
            check_rsp("rw_rsp", rw_rsp, e_rw);
        end else begin
            check_idle("rw_rsp", rw_rsp);
        end
        if (e_ro.valid) begin
            check_rsp("ro_rsp", ro_rsp, e_ro);
        end else begin
            check_idle("ro_rsp", ro_rsp);
        end
    endtask

    task automatic apply_row(stim_t s);
        int                b;
        read_rsp_t         exp_rw;
        read_rsp_t         exp_ro;
        logic [DATA_W-1:0] word;
        pkt_valid = s.valid;
        pkt       = s.pkt;
        b         = int'(s.pkt.bank);
        exp_rw.valid = s.valid && !s.pkt.rw_csb && s.pkt.rw_web;
        exp_rw.bank  = s.pkt.bank;
        exp_rw.data  = ref_mem[b][s.pkt.rw_addr];
        exp_ro.valid = s.valid && !s.pkt.ro_csb;
        exp_ro.bank  = s.pkt.bank;
        exp_ro.data  = ref_mem[b][s.pkt.ro_addr];
        exp_rw_q.push_back(exp_rw);
        exp_ro_q.push_back(exp_ro);
        // Write lands after the reads above took the old word
        if (s.valid && !s.pkt.rw_csb && !s.pkt.rw_web) begin
            word = ref_mem[b][s.pkt.rw_addr];
            for (int k = 0; k < MASK_W; k++) begin
                if (s.pkt.wmask[k]) begin
                    word[k*BYTE_W +: BYTE_W] = s.pkt.wdata[k*BYTE_W +: BYTE_W];
                end
            end
            ref_mem[b][s.pkt.rw_addr] = word;
        end
    endtask

    initial begin
        stim_t     idle_stim;
        read_rsp_t reset_rsp;
        rst_n     = 1'b0;
        pkt_valid = 1'b0;
        pkt       = '0;
        rng_state = 32'hc27;
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_in);
        reset_rsp = '{valid: 1'b0, bank: BANK0, data: '0};
        check_rsp("rw_rsp", rw_rsp, reset_rsp);
        check_rsp("ro_rsp", ro_rsp, reset_rsp);
        rst_n = 1'b1;
        repeat (PIPE_DEPTH) begin
            exp_rw_q.push_back(reset_rsp);
            exp_ro_q.push_back(reset_rsp);
        end
        foreach (stim_q[i]) begin
            @(negedge clk_in);
            check_outputs();
            apply_row(stim_q[i]);
        end
        idle_stim = '0;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk_in);
            check_outputs();
            apply_row(idle_stim);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        wait (table_built);
        #((stim_q.size() + 10) * CLK_PERIOD * 2);
        $display("Timeout: the stimulus table did not finish in the expected time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* build.f */
rtl/sram_pkg.sv
rtl/sram_packet_router.sv
rtl/sram_bank_model.sv
rtl/sram_read_return.sv
rtl/sram_subsystem.sv
verif/tb_sram_subsystem.sv
